// ==== source/lsu_cfg.svh ====
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data path and address width
`define XLEN 64

// instruction word width
`define INST_LEN 32

// byte lanes in one SRAM word
`define DMEM_LANES 8

// lane offset bits inside one word
`define DMEM_OFF_W 3

`endif

// ==== source/rv_isa_pkg.sv ====
`include "lsu_cfg.svh"

package rv_isa_pkg;

    // major opcode, instr[6:2]
    // only the two memory classes matter to this stage
    typedef enum logic [4:0] {
        OP_LOAD  = 5'b00000,
        OP_STORE = 5'b01000,
        // anything else lands here
        OP_OTHER = 5'b11111
    } opcode_e;

    // funct3 of loads and stores
    // stores reuse the b/h/w/d codes, the U forms are loads only
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_D  = 3'b011,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101,
        MEM_WU = 3'b110
    } memop_e;

    // decoded load/store command
    typedef struct packed {
        // read request wanted
        logic       rden;
        // write request wanted
        logic       wren;
        // access size and signedness
        memop_e     memop;
        // store data source register
        logic [4:0] rs2_idx;
        // load destination register
        logic [4:0] rd_idx;
    } ls_cmd_t;

endpackage

// ==== source/dmem_pkg.sv ====
`include "lsu_cfg.svh"

package dmem_pkg;

    // request toward the data SRAM
    // rd_en and wr_en are levels, never both high
    typedef struct packed {
        // byte address, natural alignment only
        logic [`XLEN-1:0]       addr;
        logic                   rd_en;
        logic                   wr_en;
        // store bytes already sitting on their lanes
        logic [`XLEN-1:0]       wr_data;
        // one enable per byte lane
        logic [`DMEM_LANES-1:0] wr_mask;
        // log2 of access bytes, 0 to 3
        logic [2:0]             wr_size;
    } dmem_req_t;

    // answer from the data SRAM
    // strobes count only while the matching enable is high
    typedef struct packed {
        // read word on rd_data this cycle
        logic                   rd_data_valid;
        // write accepted this cycle
        logic                   wr_data_ok;
        // whole aligned word, lanes untouched
        logic [`XLEN-1:0]       rd_data;
    } dmem_rsp_t;

endpackage

// ==== source/ls_decode.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module ls_decode (
    input  logic [`INST_LEN-1:0] instr_i,
    input  logic [`INST_LEN-1:0] instr_last_i,
    input  logic [`XLEN-1:0]     rs2_i,
    input  logic [`XLEN-1:0]     wb_data_i,
    output rv_isa_pkg::ls_cmd_t  cmd_o,
    output logic [`XLEN-1:0]     st_data_o
);
    import rv_isa_pkg::*;

    // class of one instruction word
    function automatic opcode_e major_op(input logic [`INST_LEN-1:0] instr);
        logic [4:0] op_bits;
        op_bits = instr[6:2];
        // compressed encodings never reach this stage as memory ops
        if (instr[1:0] != 2'b11) begin
            return OP_OTHER;
        end
        if (op_bits == OP_LOAD) begin
            return OP_LOAD;
        end
        if (op_bits == OP_STORE) begin
            return OP_STORE;
        end
        return OP_OTHER;
    endfunction

    opcode_e    cur_op;
    opcode_e    last_op;
    logic [4:0] last_rd;
    logic       fwd_hit;

    assign cur_op  = major_op(instr_i);
    assign last_op = major_op(instr_last_i);

    // command fields
    assign cmd_o.rden    = (cur_op == OP_LOAD);
    assign cmd_o.wren    = (cur_op == OP_STORE);
    // funct3 straight into the access code
    assign cmd_o.memop   = memop_e'(instr_i[14:12]);
    assign cmd_o.rs2_idx = instr_i[24:20];
    assign cmd_o.rd_idx  = instr_i[11:7];

    // destination of the load one slot ahead
    assign last_rd = instr_last_i[11:7];

    // load result not yet in the regfile when this store reads rs2
    // x0 never carries a loaded value
    assign fwd_hit = (last_op == OP_LOAD)
                   & (cur_op == OP_STORE)
                   & (last_rd == cmd_o.rs2_idx)
                   & (last_rd != 5'd0);

    // bypass mux
    assign st_data_o = fwd_hit ? wb_data_i : rs2_i;

endmodule

// ==== source/lsu_ctrl.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_ctrl (
    input  logic                clk,
    input  logic                rst_n_i,
    input  rv_isa_pkg::ls_cmd_t cmd_i,
    input  logic [`XLEN-1:0]    addr_i,
    input  dmem_pkg::dmem_rsp_t rsp_i,
    output logic [`XLEN-1:0]    addr_o,
    output logic                rd_en_o,
    output logic                wr_en_o,
    output logic                ls_not_ok_o,
    output logic                ls_misalign_o
);
    import rv_isa_pkg::*;

    logic [`DMEM_OFF_W-1:0] off;
    logic                   access;
    logic                   aligned;
    logic                   size_ok;
    logic                   legal;

    // every path below is combinational
    // request leaves in the same cycle the instruction arrives

    assign off    = addr_i[`DMEM_OFF_W-1:0];
    assign access = cmd_i.rden | cmd_i.wren;

    // natural alignment per access size
    always_comb begin
        aligned = 1'b1;
        size_ok = 1'b1;
        case (cmd_i.memop)
            MEM_B, MEM_BU: begin
                // bytes fit anywhere
                aligned = 1'b1;
            end
            MEM_H, MEM_HU: begin
                aligned = (off[0] == 1'b0);
            end
            MEM_W, MEM_WU: begin
                aligned = (off[1:0] == 2'b00);
            end
            MEM_D: begin
                aligned = (off == 3'b000);
            end
            default: begin
                // funct3 111 names no access
                size_ok = 1'b0;
            end
        endcase
        // no unsigned stores
        if (cmd_i.wren && cmd_i.memop[2]) begin
            size_ok = 1'b0;
        end
    end

    assign legal = aligned & size_ok;

    // flag only a real size at a bad offset
    // no request goes out, so no stall either
    assign ls_misalign_o = access & size_ok & ~aligned;

    // gated enables
    assign rd_en_o = cmd_i.rden & legal;
    assign wr_en_o = cmd_i.wren & legal;

    // full byte address, the SRAM picks lanes by mask and offset
    assign addr_o = addr_i;

    // hold the pipe until the strobe of the live request
    // a same-cycle answer means no stall at all
    assign ls_not_ok_o = (rd_en_o & ~rsp_i.rd_data_valid)
                       | (wr_en_o & ~rsp_i.wr_data_ok);

endmodule

// ==== source/load_ext.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module load_ext (
    input  rv_isa_pkg::memop_e     memop_i,
    input  logic [`DMEM_OFF_W-1:0] byte_off_i,
    input  logic [`XLEN-1:0]       rd_data_i,
    output logic [`XLEN-1:0]       ls_res_o
);
    import rv_isa_pkg::*;

    logic [`XLEN-1:0] lane_data;

    // addressed lane down to bit 0
    // offset in bytes, shift in bits
    assign lane_data = rd_data_i >> {byte_off_i, 3'b000};

    // size and sign
    always_comb begin
        case (memop_i)
            MEM_B: begin
                ls_res_o = {{(`XLEN-8){lane_data[7]}}, lane_data[7:0]};
            end
            MEM_BU: begin
                ls_res_o = {{(`XLEN-8){1'b0}}, lane_data[7:0]};
            end
            MEM_H: begin
                ls_res_o = {{(`XLEN-16){lane_data[15]}}, lane_data[15:0]};
            end
            MEM_HU: begin
                ls_res_o = {{(`XLEN-16){1'b0}}, lane_data[15:0]};
            end
            MEM_W: begin
                ls_res_o = {{(`XLEN-32){lane_data[31]}}, lane_data[31:0]};
            end
            MEM_WU: begin
                ls_res_o = {{(`XLEN-32){1'b0}}, lane_data[31:0]};
            end
            MEM_D: begin
                // full word, offset is zero here
                ls_res_o = lane_data;
            end
            default: begin
                ls_res_o = '0;
            end
        endcase
    end

endmodule

// ==== source/store_pack.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module store_pack (
    input  rv_isa_pkg::memop_e     memop_i,
    input  logic [`DMEM_OFF_W-1:0] byte_off_i,
    input  logic [`XLEN-1:0]       st_data_i,
    output logic [`XLEN-1:0]       wr_data_o,
    output logic [`DMEM_LANES-1:0] wr_mask_o,
    output logic [2:0]             wr_size_o
);
    import rv_isa_pkg::*;

    logic [`DMEM_LANES-1:0] base_mask;

    // lanes at offset zero, size code, replicated data
    always_comb begin
        case (memop_i)
            MEM_B: begin
                base_mask = `DMEM_LANES'h01;
                wr_size_o = 3'd0;
                // low byte on every lane
                wr_data_o = {`DMEM_LANES{st_data_i[7:0]}};
            end
            MEM_H: begin
                base_mask = `DMEM_LANES'h03;
                wr_size_o = 3'd1;
                wr_data_o = {(`DMEM_LANES/2){st_data_i[15:0]}};
            end
            MEM_W: begin
                base_mask = `DMEM_LANES'h0f;
                wr_size_o = 3'd2;
                wr_data_o = {(`DMEM_LANES/4){st_data_i[31:0]}};
            end
            MEM_D: begin
                base_mask = `DMEM_LANES'hff;
                wr_size_o = 3'd3;
                wr_data_o = st_data_i;
            end
            default: begin
                // no store form, nothing enabled
                base_mask = '0;
                wr_size_o = 3'd0;
                wr_data_o = st_data_i;
            end
        endcase
    end

    // slide enables up to the addressed lane
    // aligned access, so nothing falls off the top
    assign wr_mask_o = base_mask << byte_off_i;

endmodule

// ==== source/lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_top (
    input  logic                  clk,
    input  logic                  rst_n_i,
    // pipeline side, held while ls_not_ok_o is high
    input  logic [`INST_LEN-1:0]  instr_i,
    input  logic [`INST_LEN-1:0]  instr_last_i,
    input  logic [`XLEN-1:0]      rs2_i,
    input  logic [`XLEN-1:0]      wb_data_i,
    input  logic [`XLEN-1:0]      addr_i,
    // SRAM answer
    input  dmem_pkg::dmem_rsp_t   dmem_rsp_i,
    // results back to the pipeline
    output logic [`XLEN-1:0]      ls_res_o,
    output logic                  ls_not_ok_o,
    output logic                  ls_misalign_o,
    // SRAM request
    output dmem_pkg::dmem_req_t   dmem_req_o
);
    import rv_isa_pkg::*;

    ls_cmd_t                cmd;
    logic [`XLEN-1:0]       st_data;
    logic [`XLEN-1:0]       req_addr;
    logic                   rd_en;
    logic                   wr_en;
    logic [`XLEN-1:0]       wr_data;
    logic [`DMEM_LANES-1:0] wr_mask;
    logic [2:0]             wr_size;
    logic [`DMEM_OFF_W-1:0] byte_off;

    // lane offset shared by both datapaths
    assign byte_off = addr_i[`DMEM_OFF_W-1:0];

    // decode and store-data bypass
    ls_decode u_ls_decode (
        .instr_i      (instr_i),
        .instr_last_i (instr_last_i),
        .rs2_i        (rs2_i),
        .wb_data_i    (wb_data_i),
        .cmd_o        (cmd),
        .st_data_o    (st_data)
    );

    // alignment, enables, stall
    lsu_ctrl u_lsu_ctrl (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .cmd_i         (cmd),
        .addr_i        (addr_i),
        .rsp_i         (dmem_rsp_i),
        .addr_o        (req_addr),
        .rd_en_o       (rd_en),
        .wr_en_o       (wr_en),
        .ls_not_ok_o   (ls_not_ok_o),
        .ls_misalign_o (ls_misalign_o)
    );

    // read path
    load_ext u_load_ext (
        .memop_i    (cmd.memop),
        .byte_off_i (byte_off),
        .rd_data_i  (dmem_rsp_i.rd_data),
        .ls_res_o   (ls_res_o)
    );

    // write path
    store_pack u_store_pack (
        .memop_i    (cmd.memop),
        .byte_off_i (byte_off),
        .st_data_i  (st_data),
        .wr_data_o  (wr_data),
        .wr_mask_o  (wr_mask),
        .wr_size_o  (wr_size)
    );

    // request bundle toward the SRAM
    assign dmem_req_o.addr    = req_addr;
    assign dmem_req_o.rd_en   = rd_en;
    assign dmem_req_o.wr_en   = wr_en;
    assign dmem_req_o.wr_data = wr_data;
    assign dmem_req_o.wr_mask = wr_mask;
    assign dmem_req_o.wr_size = wr_size;

endmodule

// ==== sim/dmem_model.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module dmem_model (
    input  logic                clk,
    input  logic                rst_n_i,
    input  dmem_pkg::dmem_req_t req_i,
    output dmem_pkg::dmem_rsp_t rsp_o
);
    // 256 bytes cover every test address
    logic [7:0] mem [0:255];
    logic [1:0] lat;
    logic [1:0] held;
    logic [7:0] word_base;
    logic       answer;
    integer     seed = 32'hc75b_a086;

    // wait of 0 to 3 cycles for the next request
    function automatic logic [1:0] next_latency();
        logic [31:0] r;
        r = $random(seed);
        return r[1:0];
    endfunction

    assign word_base = {req_i.addr[7:3], 3'b000};
    // single strobe once the held request has waited long enough
    assign answer = (req_i.rd_en | req_i.wr_en) & (held == lat);

    always_comb begin
        rsp_o.rd_data_valid = req_i.rd_en & answer;
        rsp_o.wr_data_ok    = req_i.wr_en & answer;
        // whole aligned word goes out and the DUT picks its lanes
        for (int k = 0; k < `DMEM_LANES; k++) begin
            rsp_o.rd_data[8*k +: 8] = mem[word_base + k];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // low address byte xor 5a
            for (int i = 0; i < 256; i++) begin
                mem[i] <= i[7:0] ^ 8'h5a;
            end
            held <= 2'd0;
            lat  <= next_latency();
        end else if (answer) begin
            // masked lanes only
            if (req_i.wr_en) begin
                for (int k = 0; k < `DMEM_LANES; k++) begin
                    if (req_i.wr_mask[k]) begin
                        mem[word_base + k] <= req_i.wr_data[8*k +: 8];
                    end
                end
            end
            held <= 2'd0;
            lat  <= next_latency();
        end else if (req_i.rd_en | req_i.wr_en) begin
            held <= held + 2'd1;
        end else begin
            held <= 2'd0;
        end
    end

endmodule

// ==== sim/tb_lsu.sv ====
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tb_lsu;
    import rv_isa_pkg::*;
    import dmem_pkg::*;

    localparam logic [31:0] NOP = 32'h0000_0013;
    localparam logic [31:0] ADD_X7 = 32'h0020_83b3;
    localparam int WAIT_LIMIT = 32;

    // stimulus plus expected response
    typedef struct packed {
        logic [`INST_LEN-1:0] instr;
        logic [`INST_LEN-1:0] last;
        logic [`XLEN-1:0]     rs2;
        logic [`XLEN-1:0]     wb;
        logic [`XLEN-1:0]     addr;
        dmem_req_t            req;
        logic [`XLEN-1:0]     res;
        logic                 mis;
    } row_t;

    logic                 clk;
    logic                 rst_n_i;
    logic [`INST_LEN-1:0] instr;
    logic [`INST_LEN-1:0] instr_last;
    logic [`XLEN-1:0]     rs2;
    logic [`XLEN-1:0]     wb_data;
    logic [`XLEN-1:0]     addr;
    logic [`XLEN-1:0]     ls_res;
    logic                 ls_not_ok;
    logic                 ls_misalign;
    dmem_req_t            dmem_req;
    dmem_rsp_t            dmem_rsp;
    row_t                 rows[$];
    // expected memory contents, byte per address
    logic [7:0]           shadow [0:255];
    integer               seed = 32'hc75b_a086;

    lsu_top DUT (
        .clk(clk), .rst_n_i(rst_n_i), .instr_i(instr), .instr_last_i(instr_last),
        .rs2_i(rs2), .wb_data_i(wb_data), .addr_i(addr), .dmem_rsp_i(dmem_rsp),
        .ls_res_o(ls_res), .ls_not_ok_o(ls_not_ok), .ls_misalign_o(ls_misalign),
        .dmem_req_o(dmem_req)
    );

    dmem_model u_dmem (.clk(clk), .rst_n_i(rst_n_i), .req_i(dmem_req), .rsp_o(dmem_rsp));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // rs1 is x1 and the immediate is zero, address comes in separately
    function automatic logic [31:0] encode_load(logic [2:0] f3, logic [4:0] rd);
        return {12'd0, 5'd1, f3, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] encode_store(logic [2:0] f3, logic [4:0] rs2_idx);
        return {7'd0, rs2_idx, 5'd1, f3, 5'd0, 7'b0100011};
    endfunction

    // gather bytes from the shadow, then extend
    function automatic logic [63:0] expect_load(memop_e op, logic [7:0] a);
        int          nbytes;
        logic [63:0] v;
        nbytes = 1 << op[1:0];
        v = '0;
        for (int k = 0; k < nbytes; k++) begin
            v[8*k +: 8] = shadow[a + k];
        end
        if (!op[2] && nbytes < 8 && v[8*nbytes-1]) begin
            v = v | (~64'd0 << (8*nbytes));
        end
        return v;
    endfunction

    task automatic end_with_failure();
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_res(input string name, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_req(input dmem_req_t got, input dmem_req_t exp);
        logic [`XLEN-1:0] lanes;
        check_flag("dmem_req_o.rd_en", got.rd_en, exp.rd_en);
        check_flag("dmem_req_o.wr_en", got.wr_en, exp.wr_en);
        if (exp.rd_en | exp.wr_en) begin
            check_res("dmem_req_o.addr", got.addr, exp.addr);
        end
        if (exp.wr_en) begin
            if (got.wr_mask !== exp.wr_mask || got.wr_size !== exp.wr_size) begin
                $display("FAIL dmem_req_o.wr_mask/wr_size: got 0x%h/0x%h expected 0x%h/0x%h",
                         got.wr_mask, got.wr_size, exp.wr_mask, exp.wr_size);
                end_with_failure();
            end
            // unmasked lanes carry don't-care bytes
            lanes = '0;
            for (int k = 0; k < `DMEM_LANES; k++) begin
                lanes[8*k +: 8] = {8{exp.wr_mask[k]}};
            end
            check_res("dmem_req_o.wr_data", got.wr_data & lanes, exp.wr_data & lanes);
        end
    endtask

    task automatic add_row(input logic [31:0] ins, input logic [31:0] last,
                           input logic [63:0] rs2_v, input logic [63:0] wb_v,
                           input logic [7:0] a, input dmem_req_t req,
                           input logic [63:0] res, input logic mis);
        row_t r;
        r = '{ins, last, rs2_v, wb_v, {56'd0, a}, req, res, mis};
        rows.push_back(r);
    endtask

    task automatic add_load(input memop_e op, input logic [7:0] a);
        dmem_req_t req;
        req = '0;
        req.addr = {56'd0, a};
        req.rd_en = 1'b1;
        add_row(encode_load(op, 5'd5), NOP, '0, '0, a, req, expect_load(op, a), 1'b0);
    endtask

    // use_wb picks the bypassed load value as the written data
    task automatic add_store(input memop_e op, input logic [7:0] a, input logic [31:0] last,
                             input logic [4:0] rs2_idx, input logic [63:0] rs2_v,
                             input logic [63:0] wb_v, input logic use_wb);
        dmem_req_t   req;
        logic [63:0] val;
        val = use_wb ? wb_v : rs2_v;
        req = '0;
        req.addr = {56'd0, a};
        req.wr_en = 1'b1;
        req.wr_size = {1'b0, op[1:0]};
        for (int k = 0; k < (1 << op[1:0]); k++) begin
            req.wr_mask[a[2:0] + k] = 1'b1;
            req.wr_data[8*(a[2:0] + k) +: 8] = val[8*k +: 8];
            shadow[a + k] = val[8*k +: 8];
        end
        add_row(encode_store(op, rs2_idx), last, rs2_v, wb_v, a, req, '0, 1'b0);
    endtask

    task automatic add_misaligned(input memop_e op, input logic [7:0] a, input logic is_store);
        logic [31:0] ins;
        ins = is_store ? encode_store(op, 5'd6) : encode_load(op, 5'd5);
        add_row(ins, NOP, 64'h1111, '0, a, '0, '0, 1'b1);
    endtask

    task automatic build_table();
        memop_e      op;
        logic [63:0] data;
        logic [7:0]  word;
        int          idx;
        // every load form at every legal offset, sign bit clear then set
        for (int f = 0; f < 7; f++) begin
            op = memop_e'(f);
            for (int off = 0; off < 8; off += (1 << op[1:0])) begin
                add_load(op, 8'h10 + 8*f + off);
                add_load(op, 8'h90 + 8*f + off);
            end
        end
        // stores at every legal offset, each read back as a double
        idx = 0;
        for (int s = 0; s < 4; s++) begin
            for (int off = 0; off < 8; off += (1 << s)) begin
                word = 8'h48 + 8*idx;
                data = {$random(seed), $random(seed)};
                add_store(memop_e'(s), word + off, NOP, 5'd6, data, ~data, 1'b0);
                add_load(MEM_D, word);
                idx++;
            end
        end
        // load x7 then store x7, load x8 then store x7, add x7 then store x7
        data = {$random(seed), $random(seed)};
        add_store(MEM_D, 8'he8, encode_load(MEM_D, 5'd7), 5'd7, data, ~data, 1'b1);
        add_load(MEM_D, 8'he8);
        add_store(MEM_W, 8'hf4, encode_load(MEM_D, 5'd8), 5'd7, data, ~data, 1'b0);
        add_load(MEM_D, 8'hf0);
        add_store(MEM_D, 8'hf8, ADD_X7, 5'd7, data, ~data, 1'b0);
        add_load(MEM_D, 8'hf8);
        // misaligned, then proof that the word stayed intact
        add_misaligned(MEM_H, 8'h21, 1'b0);
        add_misaligned(MEM_HU, 8'h27, 1'b0);
        add_misaligned(MEM_W, 8'h22, 1'b0);
        add_misaligned(MEM_WU, 8'h25, 1'b0);
        add_misaligned(MEM_D, 8'h24, 1'b0);
        add_misaligned(MEM_H, 8'h33, 1'b1);
        add_misaligned(MEM_W, 8'h36, 1'b1);
        add_misaligned(MEM_D, 8'h31, 1'b1);
        add_load(MEM_D, 8'h30);
        // non-memory instructions
        add_row(ADD_X7, NOP, '0, '0, 8'h10, '0, '0, 1'b0);
        add_row(32'h0000_0537, NOP, '0, '0, 8'h18, '0, '0, 1'b0);
        add_row(NOP, NOP, '0, '0, 8'h00, '0, '0, 1'b0);
    endtask

    initial begin
        int   cycles;
        logic settled;
        logic exp_stall;
        rst_n_i = 1'b0;
        instr = NOP;
        instr_last = NOP;
        rs2 = '0;
        wb_data = '0;
        addr = '0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = i[7:0] ^ 8'h5a;
        end
        build_table();
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;
        foreach (rows[i]) begin
            @(posedge clk);
            instr <= rows[i].instr;
            instr_last <= rows[i].last;
            rs2 <= rows[i].rs2;
            wb_data <= rows[i].wb;
            addr <= rows[i].addr;
            // stall must track the missing strobe every cycle
            cycles = 0;
            settled = 1'b0;
            while (!settled) begin
                @(negedge clk);
                exp_stall = (rows[i].req.rd_en & ~dmem_rsp.rd_data_valid)
                          | (rows[i].req.wr_en & ~dmem_rsp.wr_data_ok);
                check_flag("ls_not_ok_o", ls_not_ok, exp_stall);
                settled = !ls_not_ok;
                cycles++;
                if (!settled && cycles > WAIT_LIMIT) begin
                    $display("timeout on row %0d waiting for ls_not_ok_o to fall", i);
                    end_with_failure();
                end
            end
            check_req(dmem_req, rows[i].req);
            check_flag("ls_misalign_o", ls_misalign, rows[i].mis);
            if (rows[i].req.rd_en) begin
                check_res("ls_res_o", ls_res, rows[i].res);
            end
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+source
source/rv_isa_pkg.sv
source/dmem_pkg.sv
source/ls_decode.sv
source/lsu_ctrl.sv
source/load_ext.sv
source/store_pack.sv
source/lsu_top.sv
sim/dmem_model.sv
sim/tb_lsu.sv
